// ==== vlog.f ====
design/rv_alu_pkg.sv
design/alu_adder.sv
design/alu_shifter.sv
design/alu.sv
design/ex_stage.sv
verification/ex_stage_props.sv
verification/tb_ex_stage.sv

// ==== Makefile ====
# Verilator build and run for the execute stage testbench

VERILATOR   ?= verilator
TOP         ?= tb_ex_stage
FILELIST    ?= vlog.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
JOBS        ?= 4
VFLAGS      ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS  ?= --lint-only --timing -Wall
PASS_STRING ?= Simulation PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the verdict comes from the log, not from the simulator exit status
run: build
	$(SIM_BIN) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_STRING)" $(LOG) || { echo "run did not pass, see $(LOG)"; exit 1; }
	@echo "run passed, log in $(LOG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/tb_ex_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_ex_stage
  import rv_alu_pkg::*;
;

  localparam int unsigned SEED       = 32'h1e37_cca3;
  localparam int          NUM_RANDOM = 400;
  localparam int          MAX_CYCLES = 1000;  // about twice the expected run
  localparam logic [XLEN-1:0] MAX_POS = {1'b0, {(XLEN-1){1'b1}}};
  localparam logic [XLEN-1:0] MIN_NEG = {1'b1, {(XLEN-1){1'b0}}};

  logic            clk_i;
  logic            rst_n_i;
  logic            valid_i;
  alu_op_e         op_i;
  logic [XLEN-1:0] a_i;
  logic [XLEN-1:0] b_i;
  logic            valid_o;
  logic [XLEN-1:0] result_o;
  logic            zf_o;
  logic            of_o;
  logic            cf_o;
  logic            sf_o;
  logic            lt_o;

  // model outputs for the operation currently on the inputs
  string           nxt_name;
  logic [XLEN-1:0] nxt_result;
  logic            nxt_zf;
  logic            nxt_of;
  logic            nxt_cf;
  logic            nxt_sf;
  logic            nxt_lt;

  // the same values delayed to line up with the registered outputs
  string           exp_name;
  logic            exp_valid;
  logic [XLEN-1:0] exp_result;
  logic            exp_zf;
  logic            exp_of;
  logic            exp_cf;
  logic            exp_sf;
  logic            exp_lt;

  int unsigned     cycles;
  int unsigned     checks;
  int unsigned     errors;

  ex_stage DUT (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .valid_i  (valid_i),
    .op_i     (op_i),
    .a_i      (a_i),
    .b_i      (b_i),
    .valid_o  (valid_o),
    .result_o (result_o),
    .zf_o     (zf_o),
    .of_o     (of_o),
    .cf_o     (cf_o),
    .sf_o     (sf_o),
    .lt_o     (lt_o)
  );

  always #2 clk_i = ~clk_i;

  // behavioral reference using the two's complement flag rules
  task automatic model_op(input logic [3:0] op, input logic [XLEN-1:0] a,
                          input logic [XLEN-1:0] b, output logic [XLEN-1:0] res,
                          output logic zf, output logic of, output logic cf,
                          output logic sf, output logic lt);
    logic              sub;
    logic [XLEN:0]     wide;
    logic [XLEN-1:0]   s;
    logic [SHAMT_W-1:0] sh;
    sub = (op == ALUOP_SUB) || (op == ALUOP_SLT) || (op == ALUOP_SLTU);
    sh  = b[SHAMT_W-1:0];
    if (sub) begin
      s  = a - b;
      cf = (a < b);  // borrow
      of = (a[XLEN-1] != b[XLEN-1]) && (s[XLEN-1] != a[XLEN-1]);
      lt = ($signed(a) < $signed(b));
    end else begin
      wide = {1'b0, a} + {1'b0, b};
      s    = wide[XLEN-1:0];
      cf   = wide[XLEN];
      of   = (a[XLEN-1] == b[XLEN-1]) && (s[XLEN-1] != a[XLEN-1]);
      lt   = of ^ s[XLEN-1];  // sign of the exact sum
    end
    zf = (s == '0);
    sf = s[XLEN-1];
    case (op)
      ALUOP_ADD, ALUOP_SUB: res = s;
      ALUOP_SLL:  res = a << sh;
      ALUOP_SRL:  res = a >> sh;
      ALUOP_SRA:  res = $signed(a) >>> sh;
      ALUOP_AND:  res = a & b;
      ALUOP_OR:   res = a | b;
      ALUOP_XOR:  res = a ^ b;
      ALUOP_SLT:  res = {{(XLEN-1){1'b0}}, ($signed(a) < $signed(b))};
      ALUOP_SLTU: res = {{(XLEN-1){1'b0}}, (a < b)};
      default:    res = '0;
    endcase
  endtask

  task automatic drive_op(input string name, input logic vld, input logic [3:0] op,
                          input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    @(posedge clk_i);
    #1;
    valid_i  = vld;
    op_i     = alu_op_e'(op);
    a_i      = a;
    b_i      = b;
    nxt_name = name;
    model_op(op, a, b, nxt_result, nxt_zf, nxt_of, nxt_cf, nxt_sf, nxt_lt);
  endtask

  function automatic logic [XLEN-1:0] rand_operand();
    int unsigned kind;
    kind = $urandom_range(7);
    case (kind)
      0:       return '0;
      1:       return MAX_POS;
      2:       return MIN_NEG;
      3:       return '1;
      default: return {$urandom(), $urandom()};
    endcase
  endfunction

  function automatic logic [3:0] rand_op();
    int unsigned r;
    r = $urandom_range(9);
    return r[3:0];
  endfunction

  task automatic check_word(input string field, input logic [XLEN-1:0] exp,
                            input logic [XLEN-1:0] act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("mismatch %s %s: expected %h, actual %h", exp_name, field, exp, act);
    end
  endtask

  task automatic check_bit(input string field, input logic exp, input logic act);
    checks++;
    assert (act === exp) else begin
      errors++;
      $display("mismatch %s %s: expected %b, actual %b", exp_name, field, exp, act);
    end
  endtask

  // expected outputs hold between operations as the stage does
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      exp_valid  <= 1'b0;
      exp_result <= '0;
      exp_zf     <= 1'b0;
      exp_of     <= 1'b0;
      exp_cf     <= 1'b0;
      exp_sf     <= 1'b0;
      exp_lt     <= 1'b0;
    end else begin
      exp_valid <= valid_i;
      if (valid_i) begin
        exp_name   <= nxt_name;
        exp_result <= nxt_result;
        exp_zf     <= nxt_zf;
        exp_of     <= nxt_of;
        exp_cf     <= nxt_cf;
        exp_sf     <= nxt_sf;
        exp_lt     <= nxt_lt;
      end
    end
  end

  always @(negedge clk_i) begin
    if (rst_n_i) begin  // outputs are settled mid-cycle
      check_bit("valid", exp_valid, valid_o);
      check_word("result", exp_result, result_o);
      check_bit("zf", exp_zf, zf_o);
      check_bit("of", exp_of, of_o);
      check_bit("cf", exp_cf, cf_o);
      check_bit("sf", exp_sf, sf_o);
      check_bit("lt", exp_lt, lt_o);
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("error: run timed out after %0d cycles", cycles);
      $display("Simulation FAILED");
      $finish;
    end
  end

  initial begin
    logic [XLEN-1:0] amts [4];
    logic [XLEN-1:0] vals [2];
    logic [3:0]      shops [3];
    clk_i     = 1'b0;
    rst_n_i   = 1'b0;
    valid_i   = 1'b0;
    op_i      = ALUOP_ADD;
    a_i       = '0;
    b_i       = '0;
    exp_name  = "reset";
    nxt_name  = "reset";
    cycles    = 0;
    checks    = 0;
    errors    = 0;
    void'($urandom(SEED));
    amts  = '{64'd0, 64'd1, 64'd63, 64'hdead_beef_0000_0fc5};  // last one has b[5:0] = 5
    vals  = '{64'hf0e1_d2c3_b4a5_9687, 64'h0123_4567_89ab_cdef};
    shops = '{ALUOP_SLL, ALUOP_SRL, ALUOP_SRA};

    repeat (5) @(posedge clk_i);
    #1;
    rst_n_i = 1'b1;

    // back-to-back arithmetic corners
    drive_op("add_max_wrap", 1'b1, ALUOP_ADD, MAX_POS, 64'd1);
    drive_op("add_min_wrap", 1'b1, ALUOP_ADD, MIN_NEG, MIN_NEG);
    drive_op("add_carry_zero", 1'b1, ALUOP_ADD, '1, 64'd1);
    drive_op("sub_min_wrap", 1'b1, ALUOP_SUB, MIN_NEG, 64'd1);
    drive_op("sub_max_wrap", 1'b1, ALUOP_SUB, MAX_POS, '1);
    drive_op("sub_equal", 1'b1, ALUOP_SUB, 64'h1234_5678_9abc_def0, 64'h1234_5678_9abc_def0);
    drive_op("sub_borrow", 1'b1, ALUOP_SUB, 64'd0, 64'd1);

    foreach (shops[i]) begin
      foreach (vals[j]) begin
        foreach (amts[k]) begin
          drive_op("shift_corner", 1'b1, shops[i], vals[j], amts[k]);
        end
      end
    end

    drive_op("logic_and", 1'b1, ALUOP_AND, 64'hff00_ff00_aaaa_5555, 64'h0ff0_0ff0_ffff_0000);
    drive_op("logic_or", 1'b1, ALUOP_OR, 64'hff00_ff00_aaaa_5555, 64'h0ff0_0ff0_ffff_0000);
    drive_op("logic_xor", 1'b1, ALUOP_XOR, 64'hff00_ff00_aaaa_5555, 64'h0ff0_0ff0_ffff_0000);
    drive_op("slt_equal", 1'b1, ALUOP_SLT, MIN_NEG, MIN_NEG);
    drive_op("slt_neg_pos", 1'b1, ALUOP_SLT, '1, 64'd1);
    drive_op("slt_pos_neg", 1'b1, ALUOP_SLT, 64'd1, '1);
    drive_op("sltu_equal", 1'b1, ALUOP_SLTU, 64'd7, 64'd7);
    drive_op("sltu_small_big", 1'b1, ALUOP_SLTU, 64'd1, '1);
    drive_op("sltu_big_small", 1'b1, ALUOP_SLTU, '1, 64'd1);
    drive_op("reserved_op", 1'b1, 4'd12, 64'd5, 64'd9);

    // idle cycles with changing inputs so the outputs must hold
    repeat (3) drive_op("idle", 1'b0, rand_op(), rand_operand(), rand_operand());

    for (int n = 0; n < NUM_RANDOM; n++) begin
      if ($urandom_range(3) == 0) begin
        drive_op("idle", 1'b0, rand_op(), rand_operand(), rand_operand());
      end
      drive_op("random", 1'b1, rand_op(), rand_operand(), rand_operand());
    end

    repeat (2) drive_op("drain", 1'b0, 4'd0, '0, '0);
    @(negedge clk_i);
    @(negedge clk_i);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule : tb_ex_stage

`default_nettype wire

// ==== verification/ex_stage_props.sv ====
`default_nettype none
`timescale 1ns/1ps

module ex_stage_props
  import rv_alu_pkg::*;
(
  input wire logic            clk_i,
  input wire logic            rst_n_i,
  input wire logic            valid_i,
  input wire alu_op_e         op_i,
  input wire logic            valid_out_i,
  input wire logic [XLEN-1:0] result_i,
  input wire logic            zf_i,
  input wire logic            of_i,
  input wire logic            cf_i,
  input wire logic            sf_i,
  input wire logic            lt_i
);

  // one-cycle stage without stalls
  valid_delay_a: assert property (@(posedge clk_i)
    rst_n_i |=> (valid_out_i == $past(valid_i)))
    else $error("valid_o is not valid_i delayed by one cycle");

  reset_zero_a: assert property (@(posedge clk_i)
    !rst_n_i |=> (!valid_out_i && (result_i == '0) && !zf_i && !of_i && !cf_i && !sf_i && !lt_i))
    else $error("outputs are not zero after reset");

  // registers only load on an operation
  hold_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (!valid_out_i && $past(rst_n_i))
    |-> ($stable(result_i) && $stable({zf_i, of_i, cf_i, sf_i, lt_i})))
    else $error("result or flags changed without an operation");

  slt_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_out_i && ($past(op_i) == ALUOP_SLT)) |-> (result_i == {{(XLEN-1){1'b0}}, lt_i}))
    else $error("SLT result differs from lt flag");

endmodule : ex_stage_props

bind ex_stage ex_stage_props u_props (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .valid_i     (valid_i),
  .op_i        (op_i),
  .valid_out_i (valid_o),
  .result_i    (result_o),
  .zf_i        (zf_o),
  .of_i        (of_o),
  .cf_i        (cf_o),
  .sf_i        (sf_o),
  .lt_i        (lt_o)
);

`default_nettype wire

// ==== design/ex_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module ex_stage
  import rv_alu_pkg::*;
(
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,
  input  wire logic            valid_i,   // one-cycle operation strobe
  input  wire alu_op_e         op_i,
  input  wire logic [XLEN-1:0] a_i,
  input  wire logic [XLEN-1:0] b_i,
  output logic                 valid_o,   // result valid, one cycle after valid_i
  output logic      [XLEN-1:0] result_o,
  output logic                 zf_o,
  output logic                 of_o,
  output logic                 cf_o,
  output logic                 sf_o,
  output logic                 lt_o
);

  logic [XLEN-1:0] alu_result;
  logic            alu_zf;
  logic            alu_of;
  logic            alu_cf;
  logic            alu_sf;
  logic            alu_lt;

  logic            valid_q;
  logic [XLEN-1:0] result_q;
  logic            zf_q;
  logic            of_q;
  logic            cf_q;
  logic            sf_q;
  logic            lt_q;

  alu u_alu (
    .a_i      (a_i),
    .op_i     (op_i),
    .b_i      (b_i),
    .result_o (alu_result),
    .zf_o     (alu_zf),
    .of_o     (alu_of),
    .cf_o     (alu_cf),
    .sf_o     (alu_sf),
    .lt_o     (alu_lt)
  );

  // no back-pressure, valid just follows the strobe
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // capture only on an operation, outputs hold otherwise
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      result_q <= '0;
      zf_q     <= 1'b0;
      of_q     <= 1'b0;
      cf_q     <= 1'b0;
      sf_q     <= 1'b0;
      lt_q     <= 1'b0;
    end else if (valid_i) begin
      result_q <= alu_result;
      zf_q     <= alu_zf;
      of_q     <= alu_of;
      cf_q     <= alu_cf;
      sf_q     <= alu_sf;
      lt_q     <= alu_lt;
    end
  end

  assign valid_o  = valid_q;
  assign result_o = result_q;
  assign zf_o     = zf_q;
  assign of_o     = of_q;
  assign cf_o     = cf_q;
  assign sf_o     = sf_q;
  assign lt_o     = lt_q;

endmodule : ex_stage

`default_nettype wire

// ==== design/alu.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu
  import rv_alu_pkg::*;
(
  input  wire logic [XLEN-1:0] a_i,
  input  wire alu_op_e         op_i,
  input  wire logic [XLEN-1:0] b_i,
  output logic      [XLEN-1:0] result_o,
  output logic                 zf_o,
  output logic                 of_o,
  output logic                 cf_o,
  output logic                 sf_o,
  output logic                 lt_o
);

  logic            sub_sel;    // adder in subtract mode
  logic            shr_sel;    // shifter right
  logic            sra_sel;    // shifter arithmetic
  logic [XLEN-1:0] sum;
  logic [XLEN-1:0] shift_res;
  logic [XLEN-1:0] and_res;
  logic [XLEN-1:0] or_res;
  logic [XLEN-1:0] xor_res;
  logic            add_zf;
  logic            add_of;
  logic            add_cf;
  logic            add_sf;
  logic            add_lt;

  // compares need a - b as well
  assign sub_sel = (op_i == ALUOP_SUB) || (op_i == ALUOP_SLT) || (op_i == ALUOP_SLTU);
  assign shr_sel = (op_i == ALUOP_SRL) || (op_i == ALUOP_SRA);
  assign sra_sel = (op_i == ALUOP_SRA);

  alu_adder u_adder (
    .a_i   (a_i),
    .b_i   (b_i),
    .sub_i (sub_sel),
    .sum_o (sum),
    .zf_o  (add_zf),
    .of_o  (add_of),
    .cf_o  (add_cf),
    .sf_o  (add_sf),
    .lt_o  (add_lt)
  );

  alu_shifter u_shifter (
    .data_i  (a_i),
    .shamt_i (b_i[SHAMT_W-1:0]),  // upper bits of b ignored
    .right_i (shr_sel),
    .arith_i (sra_sel),
    .shift_o (shift_res)
  );

  assign and_res = a_i & b_i;
  assign or_res  = a_i | b_i;
  assign xor_res = a_i ^ b_i;

  always_comb begin
    unique case (op_i)
      ALUOP_ADD,
      ALUOP_SUB:  result_o = sum;
      ALUOP_SLL,
      ALUOP_SRL,
      ALUOP_SRA:  result_o = shift_res;
      ALUOP_AND:  result_o = and_res;
      ALUOP_OR:   result_o = or_res;
      ALUOP_XOR:  result_o = xor_res;
      ALUOP_SLT:  result_o = {{(XLEN-1){1'b0}}, add_lt};  // signed less than
      ALUOP_SLTU: result_o = {{(XLEN-1){1'b0}}, add_cf};  // borrow = unsigned less than
      default:    result_o = '0;                          // reserved codes
    endcase
  end

  // flags always come from the adder, add mode for non-arith ops
  assign zf_o = add_zf;
  assign of_o = add_of;
  assign cf_o = add_cf;
  assign sf_o = add_sf;
  assign lt_o = add_lt;

endmodule : alu

`default_nettype wire

// ==== design/alu_shifter.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu_shifter
  import rv_alu_pkg::*;
(
  input  wire logic [XLEN-1:0]    data_i,
  input  wire logic [SHAMT_W-1:0] shamt_i,
  input  wire logic               right_i,  // SRL or SRA
  input  wire logic               arith_i,  // SRA, only meaningful with right_i
  output logic      [XLEN-1:0]    shift_o
);

  // pure wiring, mirrors bit i to bit XLEN-1-i
  function automatic logic [XLEN-1:0] bit_rev(input logic [XLEN-1:0] v);
    logic [XLEN-1:0] r;
    r = '0;
    for (int i = 0; i < XLEN; i++) begin
      r[i] = v[XLEN-1-i];
    end
    return r;
  endfunction

  logic [XLEN-1:0] data_rev;
  logic [XLEN-1:0] shl_in;    // operand fed to the single left shifter
  logic [XLEN-1:0] shl_out;
  logic [XLEN-1:0] sll_res;
  logic [XLEN-1:0] srl_res;
  logic [XLEN-1:0] sra_mask;  // ones where the shifted data survives
  logic [XLEN-1:0] sra_res;
  logic            sign;

  assign data_rev = bit_rev(data_i);
  assign shl_in   = right_i ? data_rev : data_i;  // right shift as a reversed left shift

  assign shl_out = shl_in << shamt_i;

  assign sll_res = shl_out;
  assign srl_res = bit_rev(shl_out);  // undo the reversal

  // vacated high bits get the sign
  assign sign     = data_i[XLEN-1];
  assign sra_mask = {XLEN{1'b1}} >> shamt_i;
  assign sra_res  = (srl_res & sra_mask) | ({XLEN{sign}} & ~sra_mask);

  always_comb begin
    if (!right_i) begin
      shift_o = sll_res;
    end else if (arith_i) begin
      shift_o = sra_res;
    end else begin
      shift_o = srl_res;
    end
  end

endmodule : alu_shifter

`default_nettype wire

// ==== design/alu_adder.sv ====
`default_nettype none
`timescale 1ns/1ps

module alu_adder
  import rv_alu_pkg::*;
(
  input  wire logic [XLEN-1:0] a_i,
  input  wire logic [XLEN-1:0] b_i,
  input  wire logic            sub_i,   // 1: a - b, 0: a + b
  output logic      [XLEN-1:0] sum_o,
  output logic                 zf_o,
  output logic                 of_o,
  output logic                 cf_o,
  output logic                 sf_o,
  output logic                 lt_o
);

  logic [XLEN:0] a_ext;    // double sign bit operand a
  logic [XLEN:0] b_ext;    // double sign bit operand b, inverted for sub
  logic [XLEN:0] cin;      // +1 completes two's complement
  logic [XLEN:0] sum_ext;
  logic          carry;    // carry out of bit XLEN-1
  logic          ovf;

  assign a_ext   = {a_i[XLEN-1], a_i};
  assign b_ext   = {b_i[XLEN-1], b_i} ^ {(XLEN+1){sub_i}};
  assign cin     = {{XLEN{1'b0}}, sub_i};
  assign sum_ext = a_ext + b_ext + cin;

  // the extension bit is a63 ^ b63 ^ carry, so the carry falls out of it
  assign carry = sum_ext[XLEN] ^ a_ext[XLEN] ^ b_ext[XLEN];

  // sign bits disagree -> signed overflow
  assign ovf = sum_ext[XLEN] ^ sum_ext[XLEN-1];

  assign sum_o = sum_ext[XLEN-1:0];

  // zero test on the visible result, for sub identical to the 65-bit test
  assign zf_o = (sum_ext[XLEN-1:0] == '0);
  assign of_o = ovf;
  assign sf_o = sum_ext[XLEN-1];
  assign cf_o = sub_i ^ carry;                 // borrow under sub
  assign lt_o = ovf ^ sum_ext[XLEN-1];         // true sign of a - b

endmodule : alu_adder

`default_nettype wire

// ==== design/rv_alu_pkg.sv ====
`default_nettype none

package rv_alu_pkg;

  // datapath width of the RV64 integer unit
  localparam int XLEN    = 64;

  // log2(XLEN), low bits of rs2 used as shift amount
  localparam int SHAMT_W = 6;

  // ALU opcodes seen by the execute stage
  typedef enum logic [3:0] {
    ALUOP_ADD  = 4'd0,  // a + b
    ALUOP_SUB  = 4'd1,  // a - b
    ALUOP_SLL  = 4'd2,  // logical left
    ALUOP_SRL  = 4'd3,  // logical right
    ALUOP_SRA  = 4'd4,  // arithmetic right
    ALUOP_AND  = 4'd5,
    ALUOP_OR   = 4'd6,
    ALUOP_XOR  = 4'd7,
    ALUOP_SLT  = 4'd8,  // signed compare, 0/1
    ALUOP_SLTU = 4'd9   // unsigned compare, 0/1
  } alu_op_e;
  // codes 10..15 are unused and give a zero result

endpackage : rv_alu_pkg

`default_nettype wire
